// File: common/stream_pkg.sv
`default_nettype none

package stream_pkg;

    localparam int word_w = 32;

    typedef logic [word_w-1:0] word_t;

    // packet number that wraps after 15.
    typedef logic [3:0] pkt_id_t;

    typedef struct packed {
        logic  last;
        word_t data;
    } in_beat_t;

    typedef struct packed {
        pkt_id_t pkt_id;
        logic    last;
        word_t   data;
    } out_beat_t;

    // code 3 is not named and acts as pass.
    typedef enum logic [1:0] {
        mode_pass = 2'd0,
        mode_xor  = 2'd1,
        mode_add  = 2'd2
    } mode_t;

    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t addr_mode  = 2'd0;  // read/write.
    localparam cfg_addr_t addr_key   = 2'd1;  // read/write.
    localparam cfg_addr_t addr_beats = 2'd2;  // read only.
    localparam cfg_addr_t addr_pkts  = 2'd3;  // read only.

endpackage

`default_nettype wire

// File: design/stream_regs.sv
`default_nettype none

module stream_regs (
    input  wire                         seq,
    input  wire                         rst_n,

    input  wire                         cfg_we,
    input  wire stream_pkg::cfg_addr_t  cfg_addr,
    input  wire stream_pkg::word_t      cfg_wdata,
    output stream_pkg::word_t           cfg_rdata,

    output stream_pkg::mode_t           mode,
    output stream_pkg::word_t           key,

    input  wire                         beat_done,
    input  wire                         pkt_done
);

    import stream_pkg::*;

    word_t beat_cnt;
    word_t pkt_cnt;

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            mode <= mode_pass;
            key  <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                addr_mode: begin
                    mode <= mode_t'(cfg_wdata[1:0]);
                end
                addr_key: begin
                    key <= cfg_wdata;
                end
                default: begin
                    // counter addresses ignore writes.
                end
            endcase
        end
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (beat_done) begin
            beat_cnt <= beat_cnt + 32'd1;
        end
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            pkt_cnt <= '0;
        end else if (pkt_done) begin
            pkt_cnt <= pkt_cnt + 32'd1;
        end
    end

    // combinational read port with no wait states.
    always_comb begin
        case (cfg_addr)
            addr_mode: begin
                cfg_rdata = word_t'(mode);
            end
            addr_key: begin
                cfg_rdata = key;
            end
            addr_beats: begin
                cfg_rdata = beat_cnt;
            end
            addr_pkts: begin
                cfg_rdata = pkt_cnt;
            end
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/stream_skid.sv
`default_nettype none

module stream_skid #(
    parameter type data_t = logic [31:0]
) (
    input  wire        seq,
    input  wire        rst_n,

    input  wire        in_valid,
    output logic       in_ready,
    input  wire data_t in_data,

    output logic       out_valid,
    input  wire        out_ready,
    output data_t      out_data
);

    // in_ready low means the skid register holds a beat.
    data_t skid_data;

    logic skid_full;
    logic out_free;
    logic load_out;
    logic load_skid;
    logic valid_d;
    logic ready_d;

    assign skid_full = !in_ready;
    assign out_free  = out_ready || !out_valid;  // output register frees up this cycle.

    // a new beat goes to the output if it is free, else it is parked.
    assign load_out  = out_free && (skid_full || in_valid);
    assign load_skid = !skid_full && !out_free && in_valid;

    always_comb begin
        valid_d = out_valid;
        ready_d = in_ready;

        if (out_free) begin
            valid_d = skid_full || in_valid;
            ready_d = 1'b1;  // skid drains into the output.
        end else if (load_skid) begin
            ready_d = 1'b0;
        end
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else begin
            out_valid <= valid_d;
            in_ready  <= ready_d;
        end
    end

    // payload path.
    always_ff @(posedge seq) begin
        if (load_out) begin
            out_data <= skid_full ? skid_data : in_data;
        end
        if (load_skid) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: design/stream_top.sv
`default_nettype none

module stream_top (
    input  wire                         seq,
    input  wire                         rst_n,

    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire stream_pkg::word_t      in_data,
    input  wire                         in_last,

    output logic                        out_valid,
    input  wire                         out_ready,
    output stream_pkg::word_t           out_data,
    output logic                        out_last,
    output stream_pkg::pkt_id_t         out_pkt_id,

    input  wire                         cfg_we,
    input  wire stream_pkg::cfg_addr_t  cfg_addr,
    input  wire stream_pkg::word_t      cfg_wdata,
    output stream_pkg::word_t           cfg_rdata
);

    import stream_pkg::*;

    in_beat_t  in_beat;
    in_beat_t  ig_beat;
    logic      ig_valid;
    logic      ig_ready;

    out_beat_t xf_beat;
    logic      xf_valid;
    logic      xf_ready;

    out_beat_t eg_beat;

    mode_t     mode;
    word_t     key;
    logic      beat_done;
    logic      pkt_done;

    assign in_beat = '{last: in_last, data: in_data};

    stream_skid #(
        .data_t (in_beat_t)
    ) u_ingress (
        .seq       (seq),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_beat),
        .out_valid (ig_valid),
        .out_ready (ig_ready),
        .out_data  (ig_beat)
    );

    stream_xform u_xform (
        .seq       (seq),
        .rst_n     (rst_n),
        .in_valid  (ig_valid),
        .in_ready  (ig_ready),
        .in_beat   (ig_beat),
        .out_valid (xf_valid),
        .out_ready (xf_ready),
        .out_beat  (xf_beat),
        .mode      (mode),
        .key       (key),
        .beat_done (beat_done),
        .pkt_done  (pkt_done)
    );

    stream_skid #(
        .data_t (out_beat_t)
    ) u_egress (
        .seq       (seq),
        .rst_n     (rst_n),
        .in_valid  (xf_valid),
        .in_ready  (xf_ready),
        .in_data   (xf_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (eg_beat)
    );

    stream_regs u_regs (
        .seq       (seq),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .mode      (mode),
        .key       (key),
        .beat_done (beat_done),
        .pkt_done  (pkt_done)
    );

    assign out_data   = eg_beat.data;
    assign out_last   = eg_beat.last;
    assign out_pkt_id = eg_beat.pkt_id;

endmodule

`default_nettype wire

// File: design/stream_xform.sv
`default_nettype none

module stream_xform (
    input  wire                        seq,
    input  wire                        rst_n,

    input  wire                        in_valid,
    output logic                       in_ready,
    input  wire stream_pkg::in_beat_t  in_beat,

    output logic                       out_valid,
    input  wire                        out_ready,
    output stream_pkg::out_beat_t      out_beat,

    input  wire stream_pkg::mode_t     mode,
    input  wire stream_pkg::word_t     key,

    output logic                       beat_done,
    output logic                       pkt_done
);

    import stream_pkg::*;

    pkt_id_t pkt_cnt;
    word_t   result;
    logic    in_fire;
    logic    out_fire;

    // stage takes a beat when it is empty or being drained.
    assign in_ready = out_ready || !out_valid;
    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    always_comb begin
        case (mode)
            mode_xor: begin
                result = in_beat.data ^ key;
            end
            mode_add: begin
                result = in_beat.data + key;  // wraps modulo 2^32.
            end
            default: begin
                result = in_beat.data;
            end
        endcase
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // numbering follows acceptance order, so a packet ends at its last input beat.
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            pkt_cnt <= '0;
        end else if (in_fire && in_beat.last) begin
            pkt_cnt <= pkt_cnt + 4'd1;
        end
    end

    always_ff @(posedge seq) begin
        if (in_fire) begin
            out_beat.pkt_id <= pkt_cnt;
            out_beat.last   <= in_beat.last;
            out_beat.data   <= result;
        end
    end

    assign beat_done = out_fire;
    assign pkt_done  = out_fire && out_beat.last;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the stream datapath testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=build
log="$build_dir/sim.log"

if ! mkdir -p "$build_dir"; then
    echo "cannot create $build_dir"
    exit 1
fi

if ! verilator --binary --timing --assert --top-module stream_tb \
        -Mdir "$build_dir" -o stream_sim -f sim.f; then
    echo "compile failed"
    exit 1
fi

"$build_dir/stream_sim" > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
    echo "result: fail"
    exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$log"; then
    echo "result: no pass line in $log"
    exit 1
fi

echo "result: pass"
exit 0

// File: sim.f
common/stream_pkg.sv
design/stream_skid.sv
design/stream_xform.sv
design/stream_regs.sv
design/stream_top.sv
verif/stream_assertions.sv
verif/stream_checker.sv
verif/stream_tb.sv

// File: verif/stream_assertions.sv
`default_nettype none

module stream_assertions #(
    parameter type data_t = logic
) (
    input wire        seq,
    input wire        rst_n,
    input wire        in_ready,
    input wire        out_valid,
    input wire        out_ready,
    input wire data_t out_data
);

    reset_empty: assert property (@(posedge seq) !rst_n |-> !out_valid)
        else $error("skid buffer output valid while reset is held");

    stall_hold: assert property (@(posedge seq) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("skid buffer output changed during a stalled transfer");

    // a parked beat implies a full output register.
    skid_has_output: assert property (@(posedge seq) disable iff (!rst_n)
        !in_ready |-> out_valid)
        else $error("skid buffer input not ready while its output is empty");

    skid_drain: assert property (@(posedge seq) disable iff (!rst_n)
        !in_ready && out_ready |=> in_ready)
        else $error("skid buffer input stayed not ready after the output drained");

endmodule

`default_nettype wire

// File: verif/stream_checker.sv
`default_nettype none

module stream_checker (
    input  wire                         seq,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire                         in_ready,
    input  wire stream_pkg::word_t      in_data,
    input  wire                         in_last,
    input  wire                         out_valid,
    input  wire                         out_ready,
    input  wire stream_pkg::word_t      out_data,
    input  wire                         out_last,
    input  wire stream_pkg::pkt_id_t    out_pkt_id,
    input  wire                         cfg_we,
    input  wire stream_pkg::cfg_addr_t  cfg_addr,
    input  wire stream_pkg::word_t      cfg_wdata,
    input  wire stream_pkg::word_t      cfg_rdata,
    input  wire                         read_chk,
    output int                          errors,
    output int                          seen
);

    import stream_pkg::*;

    out_beat_t pending [$];
    out_beat_t want;
    word_t     mode_wr;
    word_t     key_wr;
    int        in_count;
    int        last_count;
    string     test_name = "reset";

    function automatic word_t predict(word_t d);
        case (mode_wr[1:0])
            mode_xor: return d ^ key_wr;
            mode_add: return d + key_wr;  // modulo 2^32.
            default:  return d;
        endcase
    endfunction

    task automatic check_field(string field, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %h, actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    // sampled mid-cycle so each transfer seen here happens at the next rising edge.
    always @(negedge seq) begin
        if (!rst_n) begin
            mode_wr = '0;
            key_wr  = '0;
        end else begin
            if (cfg_we && cfg_addr == addr_mode) begin
                mode_wr = word_t'(cfg_wdata[1:0]);
            end
            if (cfg_we && cfg_addr == addr_key) begin
                key_wr = cfg_wdata;
            end
            if (in_valid && in_ready) begin
                want.data   = predict(in_data);
                want.last   = in_last;
                want.pkt_id = pkt_id_t'(last_count);  // earlier packets modulo 16.
                pending.push_back(want);
                in_count++;
                if (in_last) begin
                    last_count++;
                end
            end
            if (out_valid && out_ready) begin
                if (pending.size() == 0) begin
                    $display("checker: output beat with no input beat pending in test %s",
                             test_name);
                    errors++;
                end else begin
                    want = pending.pop_front();
                    check_field($sformatf("beat %0d data", seen), want.data, out_data);
                    check_field($sformatf("beat %0d last", seen), word_t'(want.last),
                                word_t'(out_last));
                    check_field($sformatf("beat %0d pkt_id", seen), word_t'(want.pkt_id),
                                word_t'(out_pkt_id));
                end
                seen++;
            end
            if (read_chk) begin
                case (cfg_addr)
                    addr_mode:  check_field("mode readback", mode_wr, cfg_rdata);
                    addr_key:   check_field("key readback", key_wr, cfg_rdata);
                    addr_beats: check_field("beat count", word_t'(in_count), cfg_rdata);
                    addr_pkts:  check_field("packet count", word_t'(last_count), cfg_rdata);
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/stream_tb.sv
`default_nettype none

module stream_tb;

    import stream_pkg::*;

    typedef struct {
        string      name;
        logic [1:0] mode;
        word_t      key;
        int         beats;
        int         plen;
        int         stall;  // chance of out_ready low in percent.
    } test_row_t;

    localparam int n_tests = 6;

    test_row_t tests [n_tests] = '{
        '{"pass_plain",  2'd0, 32'h5A5A_0F0F, 40, 4,  0},
        '{"xor_key",     2'd1, 32'hA5A5_5A5A, 40, 5,  0},
        '{"add_wrap",    2'd2, 32'hFFFF_FFF0, 40, 8,  0},
        '{"xor_stall30", 2'd1, 32'h1234_5678, 63, 3, 30},
        '{"add_stall70", 2'd2, 32'h8000_0001, 63, 7, 70},
        '{"code3_pkts",  2'd3, 32'hDEAD_BEEF, 60, 2, 30}  // many short packets so the ids wrap.
    };

    logic      seq;
    logic      rst_n;
    logic      in_valid, in_ready, in_last;
    logic      out_valid, out_ready, out_last;
    logic      cfg_we, read_chk;
    word_t     in_data, out_data, cfg_wdata, cfg_rdata;
    pkt_id_t   out_pkt_id;
    cfg_addr_t cfg_addr;
    int        seed = 74878;
    int        errors, seen, total_beats, limit, cycles;

    stream_top UUT (
        .seq (seq), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data), .in_last (in_last),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
        .out_last (out_last), .out_pkt_id (out_pkt_id),
        .cfg_we (cfg_we), .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata)
    );

    stream_checker chk (
        .seq (seq), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data), .in_last (in_last),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
        .out_last (out_last), .out_pkt_id (out_pkt_id),
        .cfg_we (cfg_we), .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata),
        .read_chk (read_chk), .errors (errors), .seen (seen)
    );

    bind stream_skid stream_assertions #(.data_t (data_t)) u_handshake (
        .seq (seq), .rst_n (rst_n), .in_ready (in_ready),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data)
    );

    initial begin
        seq = 1'b0;
        forever #4 seq = ~seq;
    end

    always @(posedge seq) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: stopped after %0d cycles, %0d of %0d beats seen",
                     cycles, seen, total_beats);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic write_reg(cfg_addr_t addr, word_t data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge seq);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic read_check(cfg_addr_t addr);
        cfg_addr = addr;
        read_chk = 1'b1;
        @(posedge seq);
        #1;
        read_chk = 1'b0;
    endtask

    task automatic run_test(int t);
        int sent;
        bit fire;
        sent = 0;
        chk.test_name = tests[t].name;
        write_reg(addr_mode, word_t'(tests[t].mode));
        write_reg(addr_key, tests[t].key);
        while (sent < tests[t].beats) begin
            if (!in_valid) begin
                in_data  = $random(seed);
                in_last  = ((sent + 1) % tests[t].plen) == 0;
                in_valid = 1'b1;
            end
            out_ready = ({$random(seed)} % 100) >= tests[t].stall;
            @(negedge seq);
            fire = in_valid && in_ready;
            @(posedge seq);
            #1;
            if (fire) begin
                sent++;
                in_valid = 1'b0;  // the next beat is raised at once if any remain.
            end
        end
        out_ready = 1'b1;
        total_beats += tests[t].beats;
        cfg_addr = addr_beats;
        @(negedge seq);
        while (cfg_rdata != word_t'(total_beats)) @(negedge seq);
        // the egress skid can still hold beats once the counter settles.
        @(posedge seq);
        while (seen != total_beats) @(posedge seq);
        #1;
        read_check(addr_mode);
        read_check(addr_key);
        read_check(addr_beats);
        read_check(addr_pkts);
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = addr_mode;
        cfg_wdata = '0;
        read_chk  = 1'b0;
        total_beats = 0;
        limit = 200;
        foreach (tests[i]) limit += tests[i].beats * 4;
        repeat (3) @(posedge seq);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("errors: %0d, beats seen: %0d of %0d", errors, seen, total_beats);
        if (errors == 0 && seen == total_beats) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
